// ==== source/rx_settings.svh ====
/* Timing limits and widths for the ISO 14443-A PCD receive path.
   Include in any RTL file that needs a gap limit or a character width. */

`ifndef RX_SETTINGS_SVH
`define RX_SETTINGS_SVH

// ----------------------------------------
// gap counter
// ----------------------------------------

// counts cycles between pause ends, largest limit is 384
`define RX_COUNT_W      9

// gaps in cycles, one bit time is 128 cycles
`define RX_GAP_MIN      64
`define RX_Y_GAP_MIN    8
`define RX_Z_TO_X_GAP   132

// counter values that force a Y when no pause arrives
`define RX_TIMEOUT_XY   132
`define RX_TIMEOUT_Z    196
`define RX_TIMEOUT_ERR  384

// ----------------------------------------
// character layout
// ----------------------------------------

// 8 data bits then odd parity
`define RX_CHAR_BITS    9

`endif

// ==== source/iso14443a_seq_pkg.sv ====
/* Line-level sequence types for the reader-to-card direction of ISO 14443-A.
   Shared by the sequence decoder, the frame decoder and the testbench. */

package iso14443a_seq_pkg;

    // modified Miller sequences seen on the line
    // one bit time is 128 carrier cycles
    //
    // X is a pause half way through the bit time
    // Y is a bit time without any pause
    // Z is a pause at the start of the bit time
    // ERROR is a gap that fits none of the above
    typedef enum logic [1:0] {
        // pause at mid bit
        seq_x     = 2'd0,
        // no pause at all
        seq_y     = 2'd1,
        // pause at bit start
        seq_z     = 2'd2,
        // illegal spacing between pauses
        seq_error = 2'd3
    } pcd_seq_t;

endpackage

// ==== source/iso14443a_frame_pkg.sv ====
/* Character and frame layout types for decoded ISO 14443-A reader frames.
   Used on the frame decoder ports and by the testbench checks. */

package iso14443a_frame_pkg;

    // ----------------------------------------
    // character layout
    // ----------------------------------------

    // each character on the line is 9 bits
    // bit 0 to bit 7 carry data, least significant bit first
    // bit 8 is odd parity over the 8 data bits
    //
    // a short frame carries 7 bits and no parity
    // which shows up as a trailing bit count at end of frame

    // one received data byte, parity stripped
    typedef logic [7:0] data_byte_t;

    // ----------------------------------------
    // frame bookkeeping
    // ----------------------------------------

    // bits seen within the current character
    // counts 0 to 9 so 4 bits are enough
    // at end of frame this is the number of bits after the last whole character
    typedef logic [3:0] bit_count_t;

endpackage

// ==== source/sequence_decode.sv ====
/* Measures the gap between pause ends on the synchronised pause input and
   classifies each bit time as X, Y, Z or an error sequence. */

`include "rx_settings.svh"

module sequence_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    // low during a pause
    input  logic                        pause_n,
    output iso14443a_seq_pkg::pcd_seq_t seq,
    output logic                        seq_valid,
    output logic                        idle
);

    // comparator limits at counter width
    localparam logic [`RX_COUNT_W-1:0] gap_min     = `RX_COUNT_W'(`RX_GAP_MIN);
    localparam logic [`RX_COUNT_W-1:0] y_gap_min   = `RX_COUNT_W'(`RX_Y_GAP_MIN);
    localparam logic [`RX_COUNT_W-1:0] z_to_x_gap  = `RX_COUNT_W'(`RX_Z_TO_X_GAP);
    localparam logic [`RX_COUNT_W-1:0] timeout_xy  = `RX_COUNT_W'(`RX_TIMEOUT_XY);
    localparam logic [`RX_COUNT_W-1:0] timeout_z   = `RX_COUNT_W'(`RX_TIMEOUT_Z);
    localparam logic [`RX_COUNT_W-1:0] timeout_err = `RX_COUNT_W'(`RX_TIMEOUT_ERR);

    logic                        pause_n_q;
    logic                        pause_n_qq;
    logic                        pause_end;
    logic [`RX_COUNT_W-1:0]      counter;
    iso14443a_seq_pkg::pcd_seq_t seq_on_pause;
    logic                        timed_out;

    // ----------------------------------------
    // end of pause
    // ----------------------------------------

    // two stage history of the pause input
    // a low to high step between stages marks the end of a pause
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pause_n_q  <= 1'b1;
            pause_n_qq <= 1'b1;
        end else begin
            pause_n_q  <= pause_n;
            pause_n_qq <= pause_n_q;
        end
    end

    assign pause_end = pause_n_q && !pause_n_qq;

    // ----------------------------------------
    // classification
    // ----------------------------------------

    // what a pause ending now would mean, given the previous sequence
    always_comb begin
        case (seq)
            iso14443a_seq_pkg::seq_x: begin
                // Z right after X cannot be encoded
                if (counter < gap_min) begin
                    seq_on_pause = iso14443a_seq_pkg::seq_error;
                end else begin
                    seq_on_pause = iso14443a_seq_pkg::seq_x;
                end
            end
            iso14443a_seq_pkg::seq_z: begin
                if (counter < gap_min) begin
                    seq_on_pause = iso14443a_seq_pkg::seq_error;
                end else if (counter < z_to_x_gap) begin
                    seq_on_pause = iso14443a_seq_pkg::seq_z;
                end else begin
                    seq_on_pause = iso14443a_seq_pkg::seq_x;
                end
            end
            iso14443a_seq_pkg::seq_y: begin
                // Y already spent one full bit time, so the windows shift down
                if (counter < y_gap_min) begin
                    seq_on_pause = iso14443a_seq_pkg::seq_error;
                end else if (counter < gap_min) begin
                    seq_on_pause = iso14443a_seq_pkg::seq_z;
                end else begin
                    seq_on_pause = iso14443a_seq_pkg::seq_x;
                end
            end
            // once in error every pause stays an error
            default: seq_on_pause = iso14443a_seq_pkg::seq_error;
        endcase
    end

    // no pause for long enough means a Y
    always_comb begin
        case (seq)
            iso14443a_seq_pkg::seq_x,
            iso14443a_seq_pkg::seq_y: timed_out = (counter == timeout_xy);
            iso14443a_seq_pkg::seq_z: timed_out = (counter == timeout_z);
            // three bit times of quiet before leaving error
            default:                  timed_out = (counter == timeout_err);
        endcase
    end

    // ----------------------------------------
    // sequence output
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle      <= 1'b1;
            seq_valid <= 1'b0;
            seq       <= iso14443a_seq_pkg::seq_y;
            counter   <= '0;
        end else begin
            seq_valid <= 1'b0;
            if (idle) begin
                // first pause out of idle is start of communication, always Z
                if (pause_end) begin
                    seq       <= iso14443a_seq_pkg::seq_z;
                    seq_valid <= 1'b1;
                    idle      <= 1'b0;
                    counter   <= `RX_COUNT_W'(1);
                end
            end else if (pause_end) begin
                counter <= `RX_COUNT_W'(1);
                seq     <= seq_on_pause;
                // pauses after an error are swallowed silently
                if (seq != iso14443a_seq_pkg::seq_error) begin
                    seq_valid <= 1'b1;
                end
            end else if (timed_out) begin
                seq       <= iso14443a_seq_pkg::seq_y;
                seq_valid <= 1'b1;
                counter   <= `RX_COUNT_W'(1);
                // Y then Y ends the exchange
                // after an error the first Y only sets seq to Y, idle follows one bit later
                if (seq == iso14443a_seq_pkg::seq_y) begin
                    idle <= 1'b1;
                end
            end else begin
                counter <= counter + 1'b1;
            end
        end
    end

    // frame_decode has no back-pressure and relies on strobes being spaced out
    a_no_back_to_back: assert property (
        @(posedge clk) disable iff (!rst_n) seq_valid |=> !seq_valid
    ) else $error("seq_valid high on two consecutive cycles");

endmodule

// ==== source/frame_decode.sv ====
/* Applies the modified Miller rules to incoming sequences and assembles
   9-bit characters into data bytes with parity and frame events. */

`include "rx_settings.svh"

module frame_decode (
    input  logic                            clk,
    input  logic                            rst_n,
    input  iso14443a_seq_pkg::pcd_seq_t     seq,
    input  logic                            seq_valid,
    output logic                            frame_start,
    output iso14443a_frame_pkg::data_byte_t data_byte,
    output logic                            data_parity_ok,
    output logic                            data_strobe,
    output logic                            frame_end,
    output iso14443a_frame_pkg::bit_count_t last_bits,
    output logic                            frame_error
);

    // index of the parity bit within a character
    localparam iso14443a_frame_pkg::bit_count_t last_bit_idx =
        iso14443a_frame_pkg::bit_count_t'(`RX_CHAR_BITS - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_frame,
        st_error
    } frame_state_t;

    frame_state_t                    state;
    // last decoded bit, Y depends on it
    logic                            prev_bit;
    logic [`RX_CHAR_BITS-1:0]        shift_reg;
    iso14443a_frame_pkg::bit_count_t bit_count;
    logic                            bit_valid;
    logic                            bit_value;
    logic                            eof;

    // ----------------------------------------
    // Miller decode
    // ----------------------------------------

    always_comb begin
        bit_valid = 1'b0;
        bit_value = 1'b0;
        eof       = 1'b0;
        if (seq_valid && (state == st_frame)) begin
            case (seq)
                iso14443a_seq_pkg::seq_x: begin
                    bit_valid = 1'b1;
                    bit_value = 1'b1;
                end
                iso14443a_seq_pkg::seq_z: begin
                    bit_valid = 1'b1;
                end
                iso14443a_seq_pkg::seq_y: begin
                    // Y after a one is a zero, Y after a zero closes the frame
                    if (prev_bit) begin
                        bit_valid = 1'b1;
                    end else begin
                        eof = 1'b1;
                    end
                end
                default: begin
                    bit_valid = 1'b0;
                end
            endcase
        end
    end

    // ----------------------------------------
    // character assembly
    // ----------------------------------------

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (bit_valid) begin
            shift_reg <= {bit_value, shift_reg[`RX_CHAR_BITS-1:1]};
        end
    end

    // held in the shift register until the next bit, well past the strobe
    assign data_byte      = shift_reg[`RX_CHAR_BITS-2:0];
    assign data_parity_ok = ^shift_reg;
    // bit_count is only cleared at the next start of frame
    assign last_bits      = bit_count;

    // ----------------------------------------
    // frame state
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            prev_bit    <= 1'b0;
            bit_count   <= '0;
            frame_start <= 1'b0;
            data_strobe <= 1'b0;
            frame_end   <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            data_strobe <= 1'b0;
            frame_end   <= 1'b0;
            frame_error <= 1'b0;
            if (seq_valid) begin
                if ((seq == iso14443a_seq_pkg::seq_error) && (state != st_error)) begin
                    frame_error <= 1'b1;
                    state       <= st_error;
                end else begin
                    case (state)
                        st_idle: begin
                            // Z is start of frame and counts as a zero
                            if (seq == iso14443a_seq_pkg::seq_z) begin
                                frame_start <= 1'b1;
                                state       <= st_frame;
                                prev_bit    <= 1'b0;
                                bit_count   <= '0;
                            end
                        end
                        st_frame: begin
                            if (eof) begin
                                frame_end <= 1'b1;
                                state     <= st_idle;
                            end else if (bit_valid) begin
                                prev_bit <= bit_value;
                                if (bit_count == last_bit_idx) begin
                                    bit_count   <= '0;
                                    data_strobe <= 1'b1;
                                end else begin
                                    bit_count <= bit_count + 1'b1;
                                end
                            end
                        end
                        default: begin
                            // sequence_decode sends Y once the line has been quiet
                            if (seq == iso14443a_seq_pkg::seq_y) begin
                                state <= st_idle;
                            end
                        end
                    endcase
                end
            end
        end
    end

    // byte and end of frame strobes never overlap or follow back to back
    // spacing of the incoming sequences keeps them apart
    a_strobes_spaced: assert property (
        @(posedge clk) disable iff (!rst_n)
        (data_strobe || frame_end) |=> !(data_strobe || frame_end)
    ) else $error("data_strobe or frame_end on two consecutive cycles");

endmodule

// ==== source/pcd_rx_top.sv ====
/* Receive path for reader-to-card frames. Feed the synchronised pause signal
   in, take frame start, data bytes, frame end and errors out. */

module pcd_rx_top (
    input  logic                            clk,
    input  logic                            rst_n,
    // low while the reader holds a pause
    input  logic                            pause_n,
    output logic                            idle,
    output logic                            frame_start,
    output iso14443a_frame_pkg::data_byte_t data_byte,
    output logic                            data_parity_ok,
    output logic                            data_strobe,
    output logic                            frame_end,
    output iso14443a_frame_pkg::bit_count_t last_bits,
    output logic                            frame_error
);

    // one sequence per bit time, at least 8 cycles apart
    iso14443a_seq_pkg::pcd_seq_t seq;
    logic                        seq_valid;

    // pause edges to X, Y, Z and error
    sequence_decode sequence_decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pause_n   (pause_n),
        .seq       (seq),
        .seq_valid (seq_valid),
        .idle      (idle)
    );

    // sequences to bits, bytes and frame events
    frame_decode frame_decode_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .seq            (seq),
        .seq_valid      (seq_valid),
        .frame_start    (frame_start),
        .data_byte      (data_byte),
        .data_parity_ok (data_parity_ok),
        .data_strobe    (data_strobe),
        .frame_end      (frame_end),
        .last_bits      (last_bits),
        .frame_error    (frame_error)
    );

endmodule

// ==== verification/pcd_rx_model.sv ====
/* Reference model for the PCD receive path. Builds random frames, Miller codes
   them into pause timing and queues the events the decoder should report. */

`include "rx_settings.svh"

package pcd_rx_model;

    // event word is {pad, kind[1:0], flag, bits[3:0], value[7:0]}
    localparam logic [1:0] ev_start = 2'd0;
    localparam logic [1:0] ev_data  = 2'd1;
    localparam logic [1:0] ev_end   = 2'd2;
    localparam logic [1:0] ev_error = 2'd3;

    typedef logic [15:0] event_t;

    // per pause: cycles since the previous pause end, and cycles held low
    int          gap_q[$];
    int          len_q[$];
    event_t      exp_q[$];
    logic [31:0] lcg_state = 32'h8acbf0e5;

    // ----------------------------------------
    // random numbers
    // ----------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low bits of an LCG are weak, take the upper ones
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:8] % n);
    endfunction

    function automatic event_t make_event(input logic [1:0] kind, input logic [7:0] value,
                                          input logic flag, input logic [3:0] bits);
        return {1'b0, kind, flag, bits, value};
    endfunction

    // ----------------------------------------
    // pause timing
    // ----------------------------------------

    // quiet cycles after which the line reads as Y
    function automatic int timeout_after(input iso14443a_seq_pkg::pcd_seq_t prev);
        if (prev == iso14443a_seq_pkg::seq_z) begin
            return `RX_TIMEOUT_Z;
        end
        return `RX_TIMEOUT_XY;
    endfunction

    // jittered gap, clamped into the window that still reads as the wanted sequence
    function automatic int pick_gap(input iso14443a_seq_pkg::pcd_seq_t prev,
                                    input iso14443a_seq_pkg::pcd_seq_t next);
        int nominal;
        int lo;
        int hi;
        int gap;
        if (prev == iso14443a_seq_pkg::seq_y) begin
            // measured from the Y timeout, which sits 4 cycles past the next bit start
            nominal = (next == iso14443a_seq_pkg::seq_z) ? 60 : 124;
            lo      = (next == iso14443a_seq_pkg::seq_z) ? `RX_Y_GAP_MIN : `RX_GAP_MIN;
            hi      = (next == iso14443a_seq_pkg::seq_z) ? `RX_GAP_MIN - 1 : `RX_TIMEOUT_XY - 1;
        end else if ((prev == iso14443a_seq_pkg::seq_z) && (next == iso14443a_seq_pkg::seq_x)) begin
            nominal = 192;
            lo      = `RX_Z_TO_X_GAP;
            hi      = `RX_TIMEOUT_Z - 1;
        end else if (prev == iso14443a_seq_pkg::seq_z) begin
            nominal = 128;
            lo      = `RX_GAP_MIN;
            hi      = `RX_Z_TO_X_GAP - 1;
        end else begin
            nominal = 128;
            lo      = `RX_GAP_MIN;
            hi      = `RX_TIMEOUT_XY - 1;
        end
        gap = nominal + rand_below(33) - 16;
        if (gap < lo) begin
            gap = lo;
        end
        if (gap > hi) begin
            gap = hi;
        end
        return gap;
    endfunction

    // ----------------------------------------
    // frame builder
    // ----------------------------------------

    function automatic void build_frame(input logic inject_error, output int n_bytes,
                                        output logic is_short);
        logic                        bits[$];
        iso14443a_seq_pkg::pcd_seq_t seqs[$];
        iso14443a_seq_pkg::pcd_seq_t prev_seq;
        logic [7:0]                  data;
        logic                        parity;
        logic                        prev_bit;
        int                          err_at;
        int                          since;
        int                          cut;
        gap_q.delete();
        len_q.delete();
        exp_q.delete();
        n_bytes  = 1 + rand_below(4);
        is_short = (rand_below(4) == 0);
        exp_q.push_back(make_event(ev_start, 8'h00, 1'b0, 4'd0));
        for (int i = 0; i < n_bytes; i++) begin
            data   = 8'(rand_below(256));
            parity = ~(^data);
            // error frames keep good parity so the first character holds a one
            if (!inject_error && (rand_below(6) == 0)) begin
                parity = ~parity;
            end
            for (int b = 0; b < 8; b++) begin
                bits.push_back(data[b]);
            end
            bits.push_back(parity);
            exp_q.push_back(make_event(ev_data, data, (^data) ^ parity, 4'd0));
        end
        if (is_short) begin
            data = 8'(rand_below(128));
            for (int b = 0; b < 7; b++) begin
                bits.push_back(data[b]);
            end
        end
        // Y right after a one reads as a zero, so a trailing one costs an extra zero
        if (bits[bits.size() - 1]) begin
            bits.push_back(1'b0);
        end
        exp_q.push_back(make_event(ev_end, 8'h00, 1'b0,
                                   4'(bits.size() - n_bytes * `RX_CHAR_BITS)));

        // modified Miller, start of frame is a Z
        seqs.push_back(iso14443a_seq_pkg::seq_z);
        prev_bit = 1'b0;
        for (int i = 0; i < bits.size(); i++) begin
            if (bits[i]) begin
                seqs.push_back(iso14443a_seq_pkg::seq_x);
            end else if (prev_bit) begin
                seqs.push_back(iso14443a_seq_pkg::seq_y);
            end else begin
                seqs.push_back(iso14443a_seq_pkg::seq_z);
            end
            prev_bit = bits[i];
        end

        // error goes in 30 cycles after the first X, events stop there
        err_at = 0;
        if (inject_error) begin
            for (int i = 1; (i < seqs.size()) && (err_at == 0); i++) begin
                if (seqs[i] == iso14443a_seq_pkg::seq_x) begin
                    err_at = i;
                end
            end
            while (exp_q.size() > 1 + err_at / `RX_CHAR_BITS) begin
                void'(exp_q.pop_back());
            end
            exp_q.push_back(make_event(ev_error, 8'h00, 1'b0, 4'd0));
        end

        // lead in before the start of frame pause
        gap_q.push_back(12);
        len_q.push_back(2 + rand_below(5));
        prev_seq = iso14443a_seq_pkg::seq_z;
        since    = 0;
        cut      = 0;
        for (int i = 1; i < seqs.size(); i++) begin
            if (seqs[i] == iso14443a_seq_pkg::seq_y) begin
                since += timeout_after(prev_seq);
            end else begin
                gap_q.push_back(since + pick_gap(prev_seq, seqs[i]) - cut);
                len_q.push_back(2 + rand_below(5));
                since = 0;
                cut   = 0;
            end
            prev_seq = seqs[i];
            if (inject_error && (i == err_at)) begin
                gap_q.push_back(30);
                len_q.push_back(2 + rand_below(5));
                cut = 30;
            end
        end
    endfunction

endpackage

// ==== verification/tb_clock_gen.sv ====
/* Clock and reset for the testbench. Period of 4 time units, reset held
   low over the first 4 rising edges. */

module tb_clock_gen #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // released 1 time unit after an edge, same as the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== verification/pcd_rx_tb.sv ====
/* Testbench for the PCD receive path. Sends random Miller coded frames with
   jittered pause timing and compares every decoded event with the model. */

module pcd_rx_tb;

    localparam int num_frames   = 16;
    localparam int error_frame  = 6;
    localparam int event_limit  = 4000;
    localparam int idle_limit   = 2000;
    localparam int quiet_cycles = 20;

    logic                            clk;
    logic                            rst_n;
    logic                            pause_n;
    logic                            idle;
    logic                            frame_start;
    iso14443a_frame_pkg::data_byte_t data_byte;
    logic                            data_parity_ok;
    logic                            data_strobe;
    logic                            frame_end;
    iso14443a_frame_pkg::bit_count_t last_bits;
    logic                            frame_error;

    pcd_rx_model::event_t obs_q[$];
    int                   errors;
    int                   tests_run;
    int                   tests_failed;
    int                   frame_no;
    logic                 timed_out;

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pcd_rx_top pcd_rx_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .pause_n        (pause_n),
        .idle           (idle),
        .frame_start    (frame_start),
        .data_byte      (data_byte),
        .data_parity_ok (data_parity_ok),
        .data_strobe    (data_strobe),
        .frame_end      (frame_end),
        .last_bits      (last_bits),
        .frame_error    (frame_error)
    );

    // ----------------------------------------
    // monitor, samples mid cycle
    // ----------------------------------------

    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (frame_start) begin
                obs_q.push_back(pcd_rx_model::make_event(pcd_rx_model::ev_start, 8'h00, 1'b0, 4'd0));
            end
            if (data_strobe) begin
                obs_q.push_back(pcd_rx_model::make_event(pcd_rx_model::ev_data, data_byte,
                                                         data_parity_ok, 4'd0));
            end
            if (frame_end) begin
                obs_q.push_back(pcd_rx_model::make_event(pcd_rx_model::ev_end, 8'h00, 1'b0,
                                                         last_bits));
            end
            if (frame_error) begin
                obs_q.push_back(pcd_rx_model::make_event(pcd_rx_model::ev_error, 8'h00, 1'b0, 4'd0));
            end
        end
    end

    function automatic string describe_event(input pcd_rx_model::event_t ev);
        case (ev[14:13])
            pcd_rx_model::ev_start: return "frame_start";
            pcd_rx_model::ev_data:  return $sformatf("data %h parity_ok %b", ev[7:0], ev[12]);
            pcd_rx_model::ev_end:   return $sformatf("frame_end last_bits %0d", ev[11:8]);
            default:                return "frame_error";
        endcase
    endfunction

    // ----------------------------------------
    // stimulus and waits
    // ----------------------------------------

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic send_pauses();
        for (int i = 0; i < pcd_rx_model::gap_q.size(); i++) begin
            repeat (pcd_rx_model::gap_q[i] - pcd_rx_model::len_q[i]) tick();
            pause_n = 1'b0;
            repeat (pcd_rx_model::len_q[i]) tick();
            pause_n = 1'b1;
        end
    endtask

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        while ((rst_n !== 1'b1) && (waited < 100)) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released, gave up at time %0t", $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_events(input int count);
        int waited;
        waited = 0;
        while ((obs_q.size() < count) && (waited < event_limit)) begin
            @(negedge clk);
            waited++;
        end
        if (obs_q.size() < count) begin
            $display("timed out after %0d cycles with %0d of %0d events seen, at time %0t",
                     waited, obs_q.size(), count, $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_idle();
        int waited;
        waited = 0;
        while ((idle !== 1'b1) && (waited < idle_limit)) begin
            @(negedge clk);
            waited++;
        end
        if (idle !== 1'b1) begin
            $display("receiver did not return to idle within %0d cycles, at time %0t",
                     idle_limit, $time);
            timed_out = 1'b1;
        end
    endtask

    // ----------------------------------------
    // checks
    // ----------------------------------------

    task automatic check_events(output int bad);
        bad = 0;
        assert (obs_q.size() == pcd_rx_model::exp_q.size()) else begin
            $display("ERR %0t: saw %0d events, expected %0d", $time, obs_q.size(),
                     pcd_rx_model::exp_q.size());
            bad++;
        end
        for (int i = 0; (i < obs_q.size()) && (i < pcd_rx_model::exp_q.size()); i++) begin
            assert (obs_q[i] === pcd_rx_model::exp_q[i]) else begin
                $display("ERR %0t: event %0d is %s, expected %s", $time, i,
                         describe_event(obs_q[i]), describe_event(pcd_rx_model::exp_q[i]));
                bad++;
            end
        end
    endtask

    task automatic run_reset_test();
        int bad;
        bad = 0;
        tests_run++;
        for (int i = 0; i < quiet_cycles; i++) begin
            @(negedge clk);
            assert (!pcd_rx_top_inst.seq_valid && !frame_start && !data_strobe && !frame_end
                    && !frame_error && (idle === 1'b1)) else begin
                $display("ERR %0t: outputs not at rest after reset", $time);
                bad++;
            end
        end
        errors += bad;
        if (bad != 0) begin
            tests_failed++;
        end
        $display("test %0d: reset state, %s", tests_run, (bad == 0) ? "ok" : "FAILED");
    endtask

    task automatic run_frame_test(input logic inject);
        int   n_bytes;
        logic is_short;
        int   bad;
        tests_run++;
        bad = 1;
        obs_q.delete();
        pcd_rx_model::build_frame(inject, n_bytes, is_short);
        send_pauses();
        wait_for_events(pcd_rx_model::exp_q.size());
        if (!timed_out) begin
            wait_for_idle();
        end
        if (!timed_out) begin
            // catch anything that trails the last expected event
            repeat (4) @(negedge clk);
            check_events(bad);
            errors += bad;
        end
        if (bad != 0) begin
            tests_failed++;
        end
        $display("test %0d: %0d bytes%s%s, %0d events, %s", tests_run, n_bytes,
                 is_short ? " and 7 bits" : "", inject ? " with error gap" : "",
                 pcd_rx_model::exp_q.size(), (bad == 0) ? "ok" : "FAILED");
    endtask

    initial begin
        pause_n      = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        wait_for_reset();
        if (!timed_out) begin
            run_reset_test();
        end
        frame_no = 0;
        while ((frame_no < num_frames) && !timed_out) begin
            run_frame_test(frame_no == error_frame);
            frame_no++;
        end
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if ((errors == 0) && (tests_failed == 0) && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+source
source/iso14443a_seq_pkg.sv
source/iso14443a_frame_pkg.sv
source/sequence_decode.sv
source/frame_decode.sv
source/pcd_rx_top.sv
verification/pcd_rx_model.sv
verification/tb_clock_gen.sv
verification/pcd_rx_tb.sv
